//--- common/dcache_settings.svh
`ifndef DCACHE_SETTINGS_SVH
`define DCACHE_SETTINGS_SVH

// cache geometry
`define DC_WAYS        4
`define DC_SETS        64
`define DC_LINE_WORDS  16

// address split: tag | index | offset
`define DC_OFFSET_W    6
`define DC_INDEX_W     6
`define DC_TAG_W       20

`endif

//--- common/dcache_pkg.sv
package dcache_pkg;

`include "dcache_settings.svh"

    // one cpu access as sampled by stage 1
    typedef struct packed {
        logic        op;        // 1 write, 0 read
        logic [31:0] addr;
        logic [3:0]  wstrb;
        logic [31:0] wdata;
    } cpu_req_t;

    typedef logic [`DC_LINE_WORDS-1:0][31:0] line_t;

    typedef logic [`DC_WAYS-1:0] way_oh_t;

    typedef struct packed {
        logic [`DC_TAG_W-1:0] tag;
        logic                 valid;
        logic                 dirty;
    } tag_entry_t;

    // stage 2 outcome, victim fields only matter on a miss
    typedef struct packed {
        logic                 hit;
        way_oh_t              hit_way;
        way_oh_t              victim_way;
        logic [`DC_TAG_W-1:0] victim_tag;
        logic                 victim_valid;
        logic                 victim_dirty;
    } lookup_res_t;

    typedef struct packed {
        logic [31-`DC_OFFSET_W:0] line_addr;
        line_t                    line;
    } wb_req_t;

endpackage

//--- dcache/dcache_lookup.sv
`timescale 1ns/1ps

module dcache_lookup import dcache_pkg::*; (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      valid,
    input  cpu_req_t                  req_in,
    input  logic                      busy,
    input  tag_entry_t [`DC_WAYS-1:0] tag_rd,
    input  line_t [`DC_WAYS-1:0]      line_rd,
    input  way_oh_t                   plru_victim,
    output cpu_req_t                  req,
    output logic                      req_valid,
    output lookup_res_t               res,
    output logic                      hit_read_valid,
    output logic [31:0]               hit_rdata,
    output way_oh_t                   store_we,
    output logic [3:0]                store_wstrb
);
    localparam int WORD_W = $clog2(`DC_LINE_WORDS);

    logic accept;
    way_oh_t victim;

    // one request at a time, stage 2 occupancy also blocks
    assign accept = valid && !busy && !req_valid;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            req_valid <= 1'b0;
        end else begin
            req_valid <= accept;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            req <= req_in;
        end
    end

    always_comb begin
        res       = '0;
        hit_rdata = '0;
        for (int w = 0; w < `DC_WAYS; w++) begin
            res.hit_way[w] = tag_rd[w].valid && (tag_rd[w].tag == req.addr[31 -: `DC_TAG_W]);
            if (res.hit_way[w]) begin
                hit_rdata = line_rd[w][req.addr[2 +: WORD_W]];
            end
        end
        res.hit = |res.hit_way;

        // an empty way wins over the plru choice
        victim = plru_victim;
        for (int w = `DC_WAYS - 1; w >= 0; w--) begin
            if (!tag_rd[w].valid) begin
                victim = way_oh_t'(1 << w);
            end
        end
        res.victim_way = victim;
        for (int w = 0; w < `DC_WAYS; w++) begin
            if (victim[w]) begin
                res.victim_tag   = tag_rd[w].tag;
                res.victim_valid = tag_rd[w].valid;
                res.victim_dirty = tag_rd[w].dirty;
            end
        end
    end

    assign hit_read_valid = req_valid && res.hit && !req.op;
    assign store_we       = (req_valid && res.hit && req.op) ? res.hit_way : '0;
    assign store_wstrb    = req.wstrb;

    // a duplicated tag in one set would break the hit mux
    assert property (@(posedge clk) disable iff (!rst_n) req_valid |-> $onehot0(res.hit_way));

endmodule

//--- dcache/dcache_tag_array.sv
`timescale 1ns/1ps
`include "dcache_settings.svh"

module dcache_tag_array import dcache_pkg::*; (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic [`DC_INDEX_W-1:0]        rd_index,
    input  logic [`DC_INDEX_W-1:0]        wr_index,
    input  way_oh_t                       wr_way,
    input  tag_entry_t                    wr_entry,
    input  way_oh_t                       set_dirty_way,
    input  way_oh_t                       touch_way,
    input  logic                          touch,
    output tag_entry_t [`DC_WAYS-1:0]     tag_rd,
    output way_oh_t                       plru_victim
);
    logic [`DC_TAG_W-1:0] tag_mem [`DC_WAYS][`DC_SETS];
    way_oh_t              valid_q [`DC_SETS];
    way_oh_t              dirty_q [`DC_SETS];
    logic [2:0]           plru_q  [`DC_SETS];   // [0] root, [1] ways 0/1, [2] ways 2/3

    // bits point away from the way just used
    function automatic logic [2:0] plru_next(logic [2:0] t, way_oh_t w);
        logic [2:0] n;
        n = t;
        if (w[0] || w[1]) begin
            n[0] = 1'b1;
            n[1] = w[0];
        end else begin
            n[0] = 1'b0;
            n[2] = w[2];
        end
        return n;
    endfunction

    function automatic way_oh_t plru_way(logic [2:0] t);
        if (!t[0]) return t[1] ? 4'b0010 : 4'b0001;
        return t[2] ? 4'b1000 : 4'b0100;
    endfunction

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int s = 0; s < `DC_SETS; s++) begin
                valid_q[s] <= '0;
                dirty_q[s] <= '0;
                plru_q[s]  <= '0;
            end
        end else begin
            for (int w = 0; w < `DC_WAYS; w++) begin
                if (wr_way[w]) begin
                    valid_q[wr_index][w] <= wr_entry.valid;
                    dirty_q[wr_index][w] <= wr_entry.dirty;
                end else if (set_dirty_way[w]) begin
                    dirty_q[wr_index][w] <= 1'b1;   // store hit
                end
            end
            if (touch) plru_q[wr_index] <= plru_next(plru_q[wr_index], touch_way);
        end
    end

    always_ff @(posedge clk) begin
        for (int w = 0; w < `DC_WAYS; w++) begin
            if (wr_way[w]) tag_mem[w][wr_index] <= wr_entry.tag;
            tag_rd[w] <= '{tag:   tag_mem[w][rd_index],
                           valid: valid_q[rd_index][w],
                           dirty: dirty_q[rd_index][w]};
        end
        plru_victim <= plru_way(plru_q[rd_index]);
    end

endmodule

//--- dcache/dcache_data_array.sv
`timescale 1ns/1ps
`include "dcache_settings.svh"

module dcache_data_array import dcache_pkg::*; (
    input  logic                                clk,
    input  logic [`DC_INDEX_W-1:0]              rd_index,
    input  logic [`DC_INDEX_W-1:0]              wr_index,
    input  logic [$clog2(`DC_LINE_WORDS)-1:0]   word_sel,
    input  way_oh_t                             word_we,
    input  logic [3:0]                          word_strb,
    input  logic [31:0]                         word_data,
    input  way_oh_t                             line_we,
    input  line_t                               line_data,
    output line_t [`DC_WAYS-1:0]                line_rd
);
    line_t mem [`DC_WAYS][`DC_SETS];

    always_ff @(posedge clk) begin
        for (int w = 0; w < `DC_WAYS; w++) begin
            if (line_we[w]) begin
                mem[w][wr_index] <= line_data;              // refill install
            end else if (word_we[w]) begin
                for (int b = 0; b < 4; b++) begin
                    if (word_strb[b]) mem[w][wr_index][word_sel][b*8 +: 8] <= word_data[b*8 +: 8];
                end
            end
            line_rd[w] <= mem[w][rd_index];
        end
    end

    // store hits and installs come from different stages
    assert property (@(posedge clk) (word_we & line_we) == '0);

endmodule

//--- dcache/dcache_miss_ctrl.sv
`timescale 1ns/1ps

module dcache_miss_ctrl import dcache_pkg::*; (
    input  logic                 clk,
    input  logic                 rst_n,
    input  cpu_req_t             req,
    input  logic                 req_valid,
    input  lookup_res_t          res,
    input  line_t [`DC_WAYS-1:0] line_rd,
    input  logic                 r_rdy,
    input  logic                 refill_done,
    input  line_t                refill_line,
    input  logic                 wb_busy,
    output logic                 busy,
    output logic                 r_req,
    output logic [31:0]          r_addr,
    output logic                 r_data_ready,
    output logic                 wb_start,
    output wb_req_t              wb_req,
    output way_oh_t              install_way,
    output tag_entry_t           install_entry,
    output way_oh_t              line_we,
    output logic                 miss_valid,
    output logic [31:0]          miss_rdata
);
    localparam int WORD_W = $clog2(`DC_LINE_WORDS);

    typedef enum logic [2:0] {IDLE, WAIT_WB, EVICT, REQ, REFILL, INSTALL} state_t;

    state_t  state;
    way_oh_t victim_way_q;
    logic    victim_dirty_q;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= IDLE;
        end else begin
            case (state)
                IDLE:    if (req_valid && !res.hit) state <= WAIT_WB;
                WAIT_WB: if (!wb_busy) state <= EVICT;   // previous write-back must drain
                EVICT:   state <= REQ;
                REQ:     if (r_rdy) state <= REFILL;
                REFILL:  if (refill_done) state <= INSTALL;
                default: state <= IDLE;
            endcase
        end
    end

    // victim is only readable in the lookup cycle, so grab it now
    always_ff @(posedge clk) begin
        if (state == IDLE && req_valid && !res.hit) begin
            victim_way_q     <= res.victim_way;
            victim_dirty_q   <= res.victim_valid && res.victim_dirty;
            wb_req.line_addr <= {res.victim_tag, req.addr[`DC_OFFSET_W +: `DC_INDEX_W]};
            for (int w = 0; w < `DC_WAYS; w++) begin
                if (res.victim_way[w]) wb_req.line <= line_rd[w];
            end
        end
    end

    assign busy         = (state != IDLE);
    assign wb_start     = (state == EVICT) && victim_dirty_q;
    assign r_req        = (state == REQ);
    assign r_addr       = {req.addr[31:`DC_OFFSET_W], {`DC_OFFSET_W{1'b0}}};  // line base
    assign r_data_ready = (state == REFILL);

    assign miss_valid    = (state == INSTALL);
    assign install_way   = miss_valid ? victim_way_q : '0;
    assign line_we       = install_way;
    assign install_entry = '{tag: req.addr[31 -: `DC_TAG_W], valid: 1'b1, dirty: req.op};
    assign miss_rdata    = refill_line[req.addr[2 +: WORD_W]];

    // read address held steady until the handshake
    assert property (@(posedge clk) disable iff (!rst_n)
        r_req && !r_rdy |=> r_req && $stable(r_addr));

endmodule

//--- dcache/dcache_refill_buf.sv
`timescale 1ns/1ps

module dcache_refill_buf import dcache_pkg::*; (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        start,
    input  cpu_req_t    req,
    input  logic        ret_valid,
    input  logic        ret_last,
    input  logic [31:0] r_data_bus,
    output logic        refill_done,
    output line_t       refill_line
);
    localparam int WORD_W = $clog2(`DC_LINE_WORDS);

    logic [WORD_W-1:0] beat;
    logic [31:0]       word;

    // pending store lands on top of the fetched word
    always_comb begin
        word = r_data_bus;
        if (req.op && beat == req.addr[2 +: WORD_W]) begin
            for (int b = 0; b < 4; b++) begin
                if (req.wstrb[b]) word[b*8 +: 8] = req.wdata[b*8 +: 8];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            beat        <= '0;
            refill_done <= 1'b0;
        end else begin
            refill_done <= ret_valid && ret_last;
            if (start) beat <= '0;      // held at zero while the address is out
            else if (ret_valid) beat <= beat + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (ret_valid) refill_line[beat] <= word;
    end

    assert property (@(posedge clk) disable iff (!rst_n)
        ret_valid && ret_last |-> beat == WORD_W'(`DC_LINE_WORDS - 1));

endmodule

//--- dcache/dcache_wb_buf.sv
`timescale 1ns/1ps

module dcache_wb_buf import dcache_pkg::*; (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        wb_start,
    input  wb_req_t     wb_req,
    input  logic        w_rdy,
    input  logic        w_data_ready,
    input  logic        b_valid,
    output logic        wb_busy,
    output logic        w_req,
    output logic [31:0] w_addr,
    output logic        w_data_req,
    output logic [31:0] w_data_bus,
    output logic        w_last,
    output logic [3:0]  w_strb,
    output logic        b_ready
);
    localparam int WORD_W = $clog2(`DC_LINE_WORDS);

    typedef enum logic [1:0] {IDLE, ADDR, DATA, RESP} state_t;

    state_t            state;
    wb_req_t           held;
    logic [WORD_W-1:0] beat;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= IDLE;
            beat  <= '0;
        end else begin
            case (state)
                IDLE: if (wb_start) state <= ADDR;
                ADDR: if (w_rdy) state <= DATA;
                DATA: if (w_data_ready) begin
                    beat <= beat + 1'b1;            // wraps to zero after the last beat
                    if (w_last) state <= RESP;
                end
                RESP: if (b_valid) state <= IDLE;
                default: state <= IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (wb_start) held <= wb_req;
    end

    assign wb_busy    = (state != IDLE);
    assign w_req      = (state == ADDR);
    assign w_addr     = {held.line_addr, {`DC_OFFSET_W{1'b0}}};
    assign w_data_req = (state == DATA);
    assign w_data_bus = held.line[beat];
    assign w_last     = w_data_req && (beat == WORD_W'(`DC_LINE_WORDS - 1));
    assign w_strb     = 4'hf;   // always full words
    assign b_ready    = (state == RESP);

    assert property (@(posedge clk) disable iff (!rst_n) wb_start |-> !wb_busy);

endmodule

//--- dcache/dcache_top.sv
`timescale 1ns/1ps

module dcache_top import dcache_pkg::*; (
    input  logic        clk,
    input  logic        rst_n,
    // cpu side
    input  logic        valid,
    input  logic        op,            // 1 write, 0 read
    input  logic [31:0] addr,
    input  logic [3:0]  wstrb,
    input  logic [31:0] w_data_cpu,
    output logic        data_valid,
    output logic [31:0] r_data_cpu,
    // bus read
    output logic        r_req,
    output logic [31:0] r_addr,
    input  logic        r_rdy,
    output logic        r_data_ready,
    input  logic        ret_valid,
    input  logic        ret_last,
    input  logic [31:0] r_data_bus,
    // bus write
    output logic        w_req,
    output logic [31:0] w_addr,
    input  logic        w_rdy,
    output logic        w_data_req,
    input  logic        w_data_ready,
    output logic        w_last,
    output logic [3:0]  w_strb,
    output logic [31:0] w_data_bus,
    input  logic        b_valid,
    output logic        b_ready
);
    localparam int WORD_W = $clog2(`DC_LINE_WORDS);

    cpu_req_t                  req_in, req;
    lookup_res_t               res;
    tag_entry_t [`DC_WAYS-1:0] tag_rd;
    line_t [`DC_WAYS-1:0]      line_rd;
    tag_entry_t                install_entry;
    way_oh_t                   plru_victim, store_we, install_way, line_we, touch_way;
    line_t                     refill_line;
    wb_req_t                   wb_req;
    logic [3:0]                store_wstrb;
    logic [31:0]               hit_rdata, miss_rdata;
    logic [WORD_W-1:0]         word_sel;
    logic [`DC_INDEX_W-1:0]    rd_index, wr_index;
    logic req_valid, busy, hit_read_valid, miss_valid, touch;
    logic refill_done, wb_busy, wb_start;

    assign req_in   = '{op: op, addr: addr, wstrb: wstrb, wdata: w_data_cpu};
    assign rd_index = addr[`DC_OFFSET_W +: `DC_INDEX_W];    // arrays follow the incoming access
    assign wr_index = req.addr[`DC_OFFSET_W +: `DC_INDEX_W];
    assign word_sel = req.addr[2 +: WORD_W];

    assign data_valid = hit_read_valid | (|store_we) | miss_valid;
    assign r_data_cpu = miss_valid ? miss_rdata : hit_rdata;

    // plru moves on any hit and on the install of a refilled line
    assign touch     = hit_read_valid | (|store_we) | (|install_way);
    assign touch_way = (|install_way) ? install_way : res.hit_way;

    dcache_lookup u_lookup (
        .clk(clk), .rst_n(rst_n), .valid(valid), .req_in(req_in), .busy(busy),
        .tag_rd(tag_rd), .line_rd(line_rd), .plru_victim(plru_victim),
        .req(req), .req_valid(req_valid), .res(res), .hit_read_valid(hit_read_valid),
        .hit_rdata(hit_rdata), .store_we(store_we), .store_wstrb(store_wstrb)
    );

    dcache_tag_array u_tag_array (
        .clk(clk), .rst_n(rst_n), .rd_index(rd_index), .wr_index(wr_index),
        .wr_way(install_way), .wr_entry(install_entry), .set_dirty_way(store_we),
        .touch_way(touch_way), .touch(touch), .tag_rd(tag_rd), .plru_victim(plru_victim)
    );

    dcache_data_array u_data_array (
        .clk(clk), .rd_index(rd_index), .wr_index(wr_index), .word_sel(word_sel),
        .word_we(store_we), .word_strb(store_wstrb), .word_data(req.wdata),
        .line_we(line_we), .line_data(refill_line), .line_rd(line_rd)
    );

    dcache_miss_ctrl u_miss_ctrl (
        .clk(clk), .rst_n(rst_n), .req(req), .req_valid(req_valid), .res(res),
        .line_rd(line_rd), .r_rdy(r_rdy), .refill_done(refill_done),
        .refill_line(refill_line), .wb_busy(wb_busy), .busy(busy), .r_req(r_req),
        .r_addr(r_addr), .r_data_ready(r_data_ready), .wb_start(wb_start), .wb_req(wb_req),
        .install_way(install_way), .install_entry(install_entry), .line_we(line_we),
        .miss_valid(miss_valid), .miss_rdata(miss_rdata)
    );

    dcache_refill_buf u_refill_buf (
        .clk(clk), .rst_n(rst_n), .start(r_req), .req(req), .ret_valid(ret_valid),
        .ret_last(ret_last), .r_data_bus(r_data_bus),
        .refill_done(refill_done), .refill_line(refill_line)
    );

    dcache_wb_buf u_wb_buf (
        .clk(clk), .rst_n(rst_n), .wb_start(wb_start), .wb_req(wb_req), .w_rdy(w_rdy),
        .w_data_ready(w_data_ready), .b_valid(b_valid), .wb_busy(wb_busy), .w_req(w_req),
        .w_addr(w_addr), .w_data_req(w_data_req), .w_data_bus(w_data_bus),
        .w_last(w_last), .w_strb(w_strb), .b_ready(b_ready)
    );

endmodule

//--- sim/axi_mem_model.sv
`timescale 1ns/1ps

module axi_mem_model (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        r_req,
    input  logic [31:0] r_addr,
    output logic        r_rdy,
    input  logic        r_data_ready,
    output logic        ret_valid,
    output logic        ret_last,
    output logic [31:0] r_data_bus,
    input  logic        w_req,
    input  logic [31:0] w_addr,
    output logic        w_rdy,
    input  logic        w_data_req,
    output logic        w_data_ready,
    input  logic        w_last,
    input  logic [3:0]  w_strb,
    input  logic [31:0] w_data_bus,
    output logic        b_valid,
    input  logic        b_ready,
    output int          errors
);
    logic [31:0] mem [logic [29:0]];   // sparse, keyed by word address
    int          seed = 50;
    logic [3:0]  beat = '0;

    function automatic logic [31:0] read_word(logic [29:0] wa);
        if (mem.exists(wa)) return mem[wa];
        return {2'b00, wa} ^ 32'h5a5a0000;     // untouched words keep the fill pattern
    endfunction

    // random back-pressure of zero to two cycles
    task automatic stall();
        int n;
        n = {$random(seed)} % 3;
        repeat (n) @(negedge clk);
    endtask

    initial begin : read_side
        logic [29:0] base;
        errors = 0;
        r_rdy = 1'b0;
        ret_valid = 1'b0;
        ret_last = 1'b0;
        r_data_bus = '0;
        forever begin
            @(negedge clk);
            if (rst_n && r_req) begin
                stall();
                base = r_addr[31:2];
                r_rdy = 1'b1;
                @(negedge clk);
                r_rdy = 1'b0;
                for (int i = 0; i < 16; i++) begin
                    stall();
                    ret_valid = 1'b1;
                    ret_last = (i == 15);
                    r_data_bus = read_word(base + 30'(i));
                    @(negedge clk);
                    ret_valid = 1'b0;
                    ret_last = 1'b0;
                end
            end
        end
    end

    initial begin : write_side
        logic [29:0] base;
        w_rdy = 1'b0;
        w_data_ready = 1'b0;
        b_valid = 1'b0;
        forever begin
            @(negedge clk);
            if (rst_n && w_req) begin
                stall();
                base = w_addr[31:2];
                w_rdy = 1'b1;
                @(negedge clk);
                w_rdy = 1'b0;
                for (int i = 0; i < 16; i++) begin
                    stall();
                    w_data_ready = 1'b1;
                    mem[base + 30'(i)] = w_data_bus;    // beat moves at the coming edge
                    @(negedge clk);
                    w_data_ready = 1'b0;
                end
                stall();
                b_valid = 1'b1;
                @(negedge clk);
                b_valid = 1'b0;
            end
        end
    end

    always @(posedge clk) begin
        if (w_data_req && w_data_ready) beat <= beat + 1'b1;
    end

    burst_base: assert property (@(posedge clk) disable iff (!rst_n)
        w_req |-> w_addr[5:0] == 6'd0)
        else begin
            errors++;
            $display("CHECK FAILED write_back: w_addr[5:0] expected 00 actual %h",
                     $sampled(w_addr[5:0]));
        end

    burst_strb: assert property (@(posedge clk) disable iff (!rst_n)
        w_data_req |-> w_strb == 4'hf)
        else begin
            errors++;
            $display("CHECK FAILED write_back: w_strb expected f actual %h", $sampled(w_strb));
        end

    burst_last: assert property (@(posedge clk) disable iff (!rst_n)
        w_data_req && w_data_ready |-> w_last == (beat == 4'd15))
        else begin
            errors++;
            $display("CHECK FAILED write_back: w_last on beat %0d expected %0b actual %0b",
                     beat + 1, beat == 4'd15, $sampled(w_last));
        end

endmodule

//--- sim/tb_dcache.sv
`timescale 1ns/1ps
`include "dcache_settings.svh"

module tb_dcache;
    localparam int HIT = 1;
    localparam int MISS = 2;
    localparam int REQ_BUDGET = 400;
    localparam int MAX_CYCLES = REQ_BUDGET * 100;   // a miss behind a write-back drain

    logic        clk = 1'b0;
    logic        rst_n, valid, op, data_valid;
    logic [31:0] addr, w_data_cpu, r_data_cpu, r_addr, r_data_bus, w_addr, w_data_bus;
    logic [3:0]  wstrb, w_strb;
    logic        r_req, r_rdy, r_data_ready, ret_valid, ret_last;
    logic        w_req, w_rdy, w_data_req, w_data_ready, w_last, b_valid, b_ready;

    logic [31:0] shadow [logic [29:0]];    // stored words by word address
    string       test_name = "reset";
    int          errors = 0;
    int          model_errors;
    int          cycles = 0;
    int          seed = 50;
    int          mode = 0;
    int          rreq_total = 0;
    int          rreq_base = 0;
    int          wb_total = 0;
    logic        cur_wr = 1'b0;
    logic        started = 1'b0;
    logic        clean_phase = 1'b0;
    logic [31:0] cur_addr = '0;
    logic [31:0] exp_data = '0;
    logic [31:0] beat_exp = '0;
    logic [3:0]  wb_beat = '0;

    always #4 clk = ~clk;

    dcache_top DUT (.*);

    axi_mem_model mem_model (.*, .errors(model_errors));

    function automatic logic [31:0] shadow_word(logic [31:0] a);
        if (shadow.exists(a[31:2])) return shadow[a[31:2]];
        return {2'b00, a[31:2]} ^ 32'h5a5a0000;    // fill pattern of the bus memory
    endfunction

    function automatic logic [31:0] make_addr(logic [`DC_TAG_W-1:0] tag,
                                              logic [`DC_INDEX_W-1:0] set, logic [3:0] word);
        return {tag, set, word, 2'b00};
    endfunction

    // one cpu access that ends the cycle after data_valid
    task automatic access(input logic wr, input logic [31:0] a, input logic [3:0] strb,
                          input logic [31:0] d, input int m);
        logic [31:0] word;
        mode = m;
        cur_wr = wr;
        cur_addr = a;
        exp_data = shadow_word(a);
        rreq_base = rreq_total;
        started = 1'b1;
        valid = 1'b1;
        op = wr;
        addr = a;
        wstrb = strb;
        w_data_cpu = d;
        @(negedge clk);
        valid = 1'b0;
        while (!data_valid) @(negedge clk);
        if (wr) begin
            word = shadow_word(a);
            for (int b = 0; b < 4; b++) begin
                if (strb[b]) word[b*8 +: 8] = d[b*8 +: 8];
            end
            shadow[a[31:2]] = word;
        end
        @(negedge clk);
    endtask

    task automatic wait_wb_idle();
        while (w_req || w_data_req || b_ready) @(negedge clk);
    endtask

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (r_req && r_rdy) rreq_total <= rreq_total + 1;
        if (w_data_req && w_data_ready) begin
            wb_beat <= wb_beat + 1'b1;
            if (w_last) wb_total <= wb_total + 1;
        end
        if (cycles == MAX_CYCLES) begin
            $display("timeout: no finish after %0d cycles", MAX_CYCLES);
            $display("Something failed");
            $finish;
        end
    end

    // expected write-back beat from the cpu's view of memory
    always @(negedge clk) beat_exp = shadow_word({w_addr[31:6], wb_beat, 2'b00});

    read_data: assert property (@(posedge clk) disable iff (!rst_n)
        data_valid && !cur_wr |-> r_data_cpu == exp_data)
        else begin
            errors++;
            $display("CHECK FAILED %s: read data expected %h actual %h",
                     test_name, exp_data, $sampled(r_data_cpu));
        end

    line_base: assert property (@(posedge clk) disable iff (!rst_n)
        r_req |-> r_addr == {cur_addr[31:6], 6'd0})
        else begin
            errors++;
            $display("CHECK FAILED %s: r_addr expected %h actual %h",
                     test_name, {cur_addr[31:6], 6'd0}, $sampled(r_addr));
        end

    hit_timing: assert property (@(posedge clk) disable iff (!rst_n)
        valid && mode == HIT |=> data_valid)
        else begin
            errors++;
            $display("CHECK FAILED %s: data_valid after hit expected 1 actual 0", test_name);
        end

    hit_no_refill: assert property (@(posedge clk) disable iff (!rst_n)
        data_valid && mode == HIT |-> rreq_total == rreq_base)
        else begin
            errors++;
            $display("CHECK FAILED %s: r_req count expected 0 actual %0d",
                     test_name, rreq_total - rreq_base);
        end

    miss_one_refill: assert property (@(posedge clk) disable iff (!rst_n)
        data_valid && mode == MISS |-> rreq_total == rreq_base + 1)
        else begin
            errors++;
            $display("CHECK FAILED %s: r_req count expected 1 actual %0d",
                     test_name, rreq_total - rreq_base);
        end

    single_pulse: assert property (@(posedge clk) disable iff (!rst_n)
        data_valid |=> !data_valid)
        else begin
            errors++;
            $display("CHECK FAILED %s: data_valid width expected 1 actual 2+", test_name);
        end

    ret_ready: assert property (@(posedge clk) disable iff (!rst_n)
        ret_valid |-> r_data_ready)
        else begin
            errors++;
            $display("CHECK FAILED %s: r_data_ready on a return beat expected 1 actual 0",
                     test_name);
        end

    beat_req: assert property (@(posedge clk) disable iff (!rst_n)
        w_data_ready |-> w_data_req)
        else begin
            errors++;
            $display("CHECK FAILED %s: w_data_req on a write beat expected 1 actual 0",
                     test_name);
        end

    resp_ready: assert property (@(posedge clk) disable iff (!rst_n)
        b_valid |-> b_ready)
        else begin
            errors++;
            $display("CHECK FAILED %s: b_ready on b_valid expected 1 actual 0", test_name);
        end

    wb_data: assert property (@(posedge clk) disable iff (!rst_n)
        w_data_req && w_data_ready |-> w_data_bus == beat_exp)
        else begin
            errors++;
            $display("CHECK FAILED %s: write-back beat expected %h actual %h",
                     test_name, beat_exp, $sampled(w_data_bus));
        end

    clean_no_wb: assert property (@(posedge clk) disable iff (!rst_n)
        clean_phase |-> !w_req)
        else begin
            errors++;
            $display("CHECK FAILED %s: w_req expected 0 actual 1", test_name);
        end

    quiet_after_reset: assert property (@(posedge clk) disable iff (!rst_n)
        !started |-> !(data_valid || r_req || r_data_ready || w_req || w_data_req
                       || w_last || b_ready))
        else begin
            errors++;
            $display("CHECK FAILED %s: control outputs expected 0 actual 1", test_name);
        end

    initial begin
        logic [31:0] r;
        int          wb_seen;
        rst_n = 1'b0;
        valid = 1'b0;
        op = 1'b0;
        addr = '0;
        wstrb = '0;
        w_data_cpu = '0;
        repeat (4) @(negedge clk);
        rst_n = 1'b1;
        repeat (3) @(negedge clk);

        test_name = "read_miss";
        access(1'b0, make_addr(20'd1, 6'd3, 4'd5), 4'h0, '0, MISS);
        test_name = "read_hit";
        access(1'b0, make_addr(20'd1, 6'd3, 4'd5), 4'h0, '0, HIT);
        access(1'b0, make_addr(20'd1, 6'd3, 4'd9), 4'h0, '0, HIT);

        test_name = "store";
        access(1'b1, make_addr(20'd2, 6'd4, 4'd6), 4'b0011, 32'hdeadbeef, MISS);
        access(1'b1, make_addr(20'd2, 6'd4, 4'd6), 4'b1000, 32'h11223344, HIT);
        access(1'b0, make_addr(20'd2, 6'd4, 4'd6), 4'h0, '0, HIT);
        access(1'b0, make_addr(20'd2, 6'd4, 4'd7), 4'h0, '0, HIT);

        test_name = "evict";
        wb_seen = wb_total;
        for (int t = 0; t < 5; t++) begin
            access(1'b1, make_addr(20'(10 + t), 6'd7, 4'(t)), (t == 2) ? 4'b0101 : 4'hf,
                   32'hc0de0000 + 32'(t), MISS);
        end
        wait_wb_idle();
        assert (wb_total > wb_seen)
            else begin
                errors++;
                $display("%s: five dirty lines in one set gave no write-back", test_name);
            end
        for (int t = 0; t < 5; t++) begin
            access(1'b0, make_addr(20'(10 + t), 6'd7, 4'(t)), 4'h0, '0, 0);
        end
        wait_wb_idle();

        test_name = "clean";
        clean_phase = 1'b1;
        for (int t = 0; t < 8; t++) begin
            access(1'b0, make_addr(20'(100 + t), 6'd30, 4'(t)), 4'h0, '0, MISS);
        end
        clean_phase = 1'b0;

        test_name = "random";
        for (int i = 0; i < 300; i++) begin
            r = $random(seed);
            access(r[0], make_addr(20'(200 + r[3:1]), 6'(40 + r[5:4]), r[9:6]), r[13:10],
                   $random(seed), 0);
        end
        wait_wb_idle();
        repeat (5) @(negedge clk);

        $display("closing report: %0d check errors, %0d bus model errors", errors, model_errors);
        if (errors == 0 && model_errors == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

//--- src.f
+incdir+common
common/dcache_pkg.sv
dcache/dcache_lookup.sv
dcache/dcache_tag_array.sv
dcache/dcache_data_array.sv
dcache/dcache_miss_ctrl.sv
dcache/dcache_refill_buf.sv
dcache/dcache_wb_buf.sv
dcache/dcache_top.sv
sim/axi_mem_model.sv
sim/tb_dcache.sv

//--- Makefile
# Verilator flow for the data cache testbench
TOP := tb_dcache

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert -f src.f --top-module dcache_top
	verilator --lint-only --timing --assert -f src.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -f src.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) | tee sim.log
	@if grep -q "Something failed" sim.log; then echo "simulation reported failure"; exit 1; fi
	@grep -q "Everything OK" sim.log

clean:
	rm -rf obj_dir sim.log
